// File: irq_ctrl.f
+incdir+.
irq_ctrl_pkg.sv
irq_ctrl_apb_regs.sv
pry2oht_tree.sv
irq_ctrl_select.sv
irq_ctrl.sv
irq_ctrl_clk_gen.sv
irq_ctrl_props.sv
irq_ctrl_tb.sv

// File: Bender.yml
package:
  name: irq_ctrl

sources:
  - include_dirs:
      - .
    files:
      - irq_ctrl_pkg.sv
      - irq_ctrl_apb_regs.sv
      - pry2oht_tree.sv
      - irq_ctrl_select.sv
      - irq_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - irq_ctrl_clk_gen.sv
      - irq_ctrl_props.sv
      - irq_ctrl_tb.sv

// File: irq_ctrl_tb.sv
// testbench top for the interrupt controller
// drives APB traffic and source patterns, the bound props do most checking

`include "irq_ctrl_defines.svh"

module irq_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // about four times the length of the stimulus
    localparam int unsigned MAX_CYCLES = 2000;
    localparam irq_ctrl_pkg::apb_data_t ALL_SRC =
        irq_ctrl_pkg::apb_data_t'({`IRQ_CTRL_NUM{1'b1}});

    logic                   clk;
    logic                   rst_n;
    irq_ctrl_pkg::irq_vec_t irq_src;
    irq_ctrl_pkg::apb_req_t apb_req;
    irq_ctrl_pkg::apb_rsp_t apb_rsp;
    logic                   irq;
    irq_ctrl_pkg::irq_id_t  irq_id;

    int unsigned read_errs;
    int unsigned cycles;

    irq_ctrl_clk_gen #(.PERIOD(10)) u_clk (.clk(clk), .rst_n(rst_n));

    irq_ctrl dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_src (irq_src),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq),
        .irq_id  (irq_id)
    );

    bind irq_ctrl irq_ctrl_props props0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_src (irq_src),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq),
        .irq_id  (irq_id)
    );

    ////////////////////////////////////////////////////////////
    // stimulus tasks, all driving on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_sources(input irq_ctrl_pkg::irq_vec_t val);
        @(negedge clk);
        irq_src = val;
    endtask

    // setup cycle, access cycle, then back to idle
    task automatic apb_write(input logic [`IRQ_CTRL_AW-1:0] addr,
                             input irq_ctrl_pkg::apb_data_t data);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req = '0;
    endtask

    // data is sampled at the edge that ends the access cycle
    task automatic apb_read(input logic [`IRQ_CTRL_AW-1:0] addr,
                            input irq_ctrl_pkg::apb_data_t exp,
                            input string name);
        irq_ctrl_pkg::apb_data_t got;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        got = apb_rsp.prdata;
        if (got !== exp) begin
            read_errs++;
            $display("error: t=%0t %s expected %h got %h", $time, name, exp, got);
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    // one pattern held long enough to reach the claim, then cleared
    task automatic random_round(input irq_ctrl_pkg::irq_vec_t pat,
                                input irq_ctrl_pkg::irq_vec_t en);
        apb_write(`IRQ_CTRL_REG_ENABLE, irq_ctrl_pkg::apb_data_t'(en));
        set_sources(pat);
        idle_cycles(3);
        set_sources('0);
        apb_write(`IRQ_CTRL_REG_CLEAR, ALL_SRC);
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        irq_ctrl_pkg::irq_vec_t pat;
        irq_ctrl_pkg::irq_vec_t en;
        int unsigned total;

        irq_src   = '0;
        apb_req   = '0;
        read_errs = 0;
        cycles    = 0;
        void'($urandom(20));

        @(posedge rst_n);
        // registers come out of reset empty
        apb_read(`IRQ_CTRL_REG_ENABLE, '0, "enable");
        apb_read(`IRQ_CTRL_REG_PENDING, '0, "pending");

        // every source as the lowest winner, random bits above it
        for (int k = 0; k < `IRQ_CTRL_NUM; k++) begin
            pat = (irq_ctrl_pkg::irq_vec_t'($urandom) & ({`IRQ_CTRL_NUM{1'b1}} << k))
                | (irq_ctrl_pkg::irq_vec_t'(1) << k);
            en  = irq_ctrl_pkg::irq_vec_t'($urandom) | (irq_ctrl_pkg::irq_vec_t'(1) << k);
            random_round(pat, en);
        end
        for (int r = 0; r < 20; r++) begin
            random_round(irq_ctrl_pkg::irq_vec_t'($urandom),
                         irq_ctrl_pkg::irq_vec_t'($urandom));
        end

        // clear moves the claim, a source held high survives
        apb_write(`IRQ_CTRL_REG_ENABLE, ALL_SRC);
        set_sources(24'h000088);
        idle_cycles(2);
        set_sources('0);
        apb_read(`IRQ_CTRL_REG_PENDING, 32'h0000_0088, "pending");
        apb_write(`IRQ_CTRL_REG_CLEAR, 32'h0000_0008);
        idle_cycles(2);
        apb_read(`IRQ_CTRL_REG_PENDING, 32'h0000_0080, "pending");
        apb_read(`IRQ_CTRL_REG_CLAIM, 32'h8000_0007, "claim");
        set_sources(24'h000080);
        apb_write(`IRQ_CTRL_REG_CLEAR, 32'h0000_0080);
        apb_read(`IRQ_CTRL_REG_PENDING, 32'h0000_0080, "pending");
        set_sources('0);
        apb_write(`IRQ_CTRL_REG_CLEAR, 32'h0000_0080);
        apb_read(`IRQ_CTRL_REG_PENDING, '0, "pending");
        idle_cycles(2);
        apb_read(`IRQ_CTRL_REG_CLAIM, '0, "claim");

        // masking hides the source but keeps it pending
        set_sources(24'h000020);
        set_sources('0);
        apb_write(`IRQ_CTRL_REG_ENABLE, ALL_SRC & ~32'h0000_0020);
        idle_cycles(2);
        apb_read(`IRQ_CTRL_REG_PENDING, 32'h0000_0020, "pending");
        apb_read(`IRQ_CTRL_REG_CLAIM, '0, "claim");
        apb_write(`IRQ_CTRL_REG_ENABLE, ALL_SRC);
        idle_cycles(2);
        apb_read(`IRQ_CTRL_REG_CLAIM, 32'h8000_0005, "claim");

        // unmapped offsets touch nothing
        apb_write(4'h1, '0);
        apb_write(4'h6, '0);
        apb_write(4'hF, 32'hFFFF_FFFF);
        apb_read(4'h2, '0, "prdata");
        apb_read(`IRQ_CTRL_REG_ENABLE, ALL_SRC, "enable");
        apb_read(`IRQ_CTRL_REG_PENDING, 32'h0000_0020, "pending");
        apb_write(`IRQ_CTRL_REG_CLEAR, 32'h0000_0020);
        idle_cycles(3);

        total = read_errs + dut0.props0.fail_cnt;
        $display("errors: read %0d, assertion %0d", read_errs, dut0.props0.fail_cnt);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: irq_ctrl_props.sv
// concurrent checks for the interrupt controller, bound into irq_ctrl
// keeps its own model of pending and enable built from the register rules

`include "irq_ctrl_defines.svh"

module irq_ctrl_props (
    input logic                   clk,
    input logic                   rst_n,
    input irq_ctrl_pkg::irq_vec_t irq_src,
    input irq_ctrl_pkg::apb_req_t apb_req,
    input irq_ctrl_pkg::apb_rsp_t apb_rsp,
    input logic                   irq,
    input irq_ctrl_pkg::irq_id_t  irq_id
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed checks, read by the testbench top at the end
    int unsigned fail_cnt;

    irq_ctrl_pkg::irq_vec_t  pend_m;
    irq_ctrl_pkg::irq_vec_t  en_m;
    irq_ctrl_pkg::irq_vec_t  act_m;
    logic                    exp_vld;
    irq_ctrl_pkg::irq_id_t   exp_id;
    logic                    acc;
    logic                    rd;
    logic                    mapped_m;
    irq_ctrl_pkg::apb_data_t claim_word;

    initial fail_cnt = 0;

    // lowest numbered set bit, zero when none is set
    function automatic irq_ctrl_pkg::irq_id_t lowest_id(input irq_ctrl_pkg::irq_vec_t v);
        irq_ctrl_pkg::irq_id_t id;
        id = '0;
        for (int i = `IRQ_CTRL_NUM - 1; i >= 0; i--) begin
            if (v[i]) begin
                id = irq_ctrl_pkg::irq_id_t'(i);
            end
        end
        return id;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    assign acc      = apb_req.psel & apb_req.penable;
    assign rd       = acc & ~apb_req.pwrite;
    assign mapped_m = apb_req.paddr inside {`IRQ_CTRL_REG_ENABLE, `IRQ_CTRL_REG_PENDING,
                                            `IRQ_CTRL_REG_CLEAR, `IRQ_CTRL_REG_CLAIM};
    assign act_m    = pend_m & en_m;
    // CLAIM layout, valid on top and index at the bottom
    assign claim_word = {irq, {(`IRQ_CTRL_DW - 1 - `IRQ_CTRL_ID_W){1'b0}}, irq_id};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_m  <= '0;
            en_m    <= '0;
            exp_vld <= 1'b0;
            exp_id  <= '0;
        end else begin
            if (acc && apb_req.pwrite && apb_req.paddr == `IRQ_CTRL_REG_ENABLE) begin
                en_m <= apb_req.pwdata[`IRQ_CTRL_NUM-1:0];
            end
            // a source that is still high keeps its bit
            if (acc && apb_req.pwrite && apb_req.paddr == `IRQ_CTRL_REG_CLEAR) begin
                pend_m <= (pend_m & ~apb_req.pwdata[`IRQ_CTRL_NUM-1:0]) | irq_src;
            end else begin
                pend_m <= pend_m | irq_src;
            end
            // claim trails the pending register by one edge
            exp_vld <= |act_m;
            exp_id  <= lowest_id(act_m);
        end
    end

    ////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clk) !rst_n |=> (!irq && irq_id == '0))
        else begin
            fail_cnt++;
            $error("irq or irq_id not cleared by reset");
        end

    a_irq: assert property (@(posedge clk) disable iff (!rst_n) irq == exp_vld)
        else begin
            fail_cnt++;
            $error("error: t=%0t irq expected %0b got %0b", $time,
                   $sampled(exp_vld), $sampled(irq));
        end

    a_irq_id: assert property (@(posedge clk) disable iff (!rst_n) irq_id == exp_id)
        else begin
            fail_cnt++;
            $error("error: t=%0t irq_id expected %0d got %0d", $time,
                   $sampled(exp_id), $sampled(irq_id));
        end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr == (acc && !mapped_m))
        else begin
            fail_cnt++;
            $error("error: t=%0t pslverr expected %0b got %0b", $time,
                   $sampled(acc && !mapped_m), $sampled(apb_rsp.pslverr));
        end

    a_claim_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (rd && apb_req.paddr == `IRQ_CTRL_REG_CLAIM) |-> apb_rsp.prdata == claim_word)
        else begin
            fail_cnt++;
            $error("error: t=%0t prdata expected %h got %h", $time,
                   $sampled(claim_word), $sampled(apb_rsp.prdata));
        end

    // unmapped reads return zero
    a_unmapped_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (rd && !mapped_m) |-> apb_rsp.prdata == '0)
        else begin
            fail_cnt++;
            $error("error: t=%0t prdata expected 0 got %h", $time,
                   $sampled(apb_rsp.prdata));
        end

endmodule

// File: irq_ctrl_clk_gen.sv
// clock and reset source for the interrupt controller testbench
// 10 ns clock, rst_n held low for the first two rising edges

module irq_ctrl_clk_gen #(
    parameter int unsigned PERIOD = 10
)(
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: irq_ctrl.sv
// top level of the interrupt controller
// APB registers feed the priority tree, the select stage drives irq and irq_id

`include "irq_ctrl_defines.svh"

module irq_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  irq_ctrl_pkg::irq_vec_t irq_src,
    input  irq_ctrl_pkg::apb_req_t apb_req,
    output irq_ctrl_pkg::apb_rsp_t apb_rsp,
    output logic                   irq,
    output irq_ctrl_pkg::irq_id_t  irq_id
);

    // pending and enabled sources
    irq_ctrl_pkg::irq_vec_t active;
    // lowest numbered active source, one-hot
    irq_ctrl_pkg::irq_vec_t oht;
    logic                   vld;
    // registered winner, also read back through CLAIM
    irq_ctrl_pkg::claim_t   claim;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    irq_ctrl_apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_src (irq_src),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .claim   (claim),
        .active  (active)
    );

    // combinational priority pick
    pry2oht_tree #(
        .WIDTH (`IRQ_CTRL_NUM),
        .SPLIT (`IRQ_CTRL_SPLIT)
    ) u_tree (
        .pry (active),
        .oht (oht),
        .vld (vld)
    );

    ////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////

    irq_ctrl_select u_select (
        .clk   (clk),
        .rst_n (rst_n),
        .oht   (oht),
        .vld   (vld),
        .claim (claim)
    );

    assign irq    = claim.vld;
    assign irq_id = claim.id;

endmodule

// File: irq_ctrl_select.sv
// output side of the interrupt controller
// encodes the one-hot winner into an index and registers it as the claim

`include "irq_ctrl_defines.svh"

module irq_ctrl_select (
    input  logic                   clk,
    input  logic                   rst_n,
    input  irq_ctrl_pkg::irq_vec_t oht,
    input  logic                   vld,
    output irq_ctrl_pkg::claim_t   claim
);

    ////////////////////////////////////////////////////////////
    // one-hot to index encoder
    ////////////////////////////////////////////////////////////

    irq_ctrl_pkg::irq_id_t id_nxt;

    // each index bit is the OR of the one-hot bits whose
    // position has that bit set
    generate
    for (genvar b = 0; b < `IRQ_CTRL_ID_W; b++) begin : enc
        irq_ctrl_pkg::irq_vec_t sel;

        for (genvar i = 0; i < `IRQ_CTRL_NUM; i++) begin : pos
            // constant per position, keeps only the contributing bits
            assign sel[i] = (((i >> b) & 1) != 0) ? oht[i] : 1'b0;
        end : pos

        assign id_nxt[b] = |sel;
    end : enc
    endgenerate

    ////////////////////////////////////////////////////////////
    // claim register
    ////////////////////////////////////////////////////////////

    // second pipeline stage after the pending register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            claim <= '0;
        end else begin
            claim.vld <= vld;
            // index is zero when nothing is pending
            claim.id  <= id_nxt;
        end
    end

endmodule

// File: pry2oht_tree.sv
// rightmost priority to one-hot converter, built as a SPLIT-way tree
// input is zero padded up to a power of SPLIT and cropped again on output
// purely combinational, vld is high when any input bit is set

module pry2oht_tree #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned SPLIT = 2
)(
    input  logic [WIDTH-1:0] pry,
    output logic [WIDTH-1:0] oht,
    output logic             vld
);

    localparam int unsigned WIDTH_LOG = $clog2(WIDTH);
    localparam int unsigned SPLIT_LOG = $clog2(SPLIT);
    // guard against a zero divisor when SPLIT is illegal
    localparam int unsigned STEP      = (SPLIT_LOG == 0) ? 1 : SPLIT_LOG;
    // tree depth, rounded up so the padded width covers WIDTH
    localparam int unsigned LEVELS    = (WIDTH_LOG + STEP - 1) / STEP;
    localparam int unsigned POWER     = SPLIT ** LEVELS;

    generate
    if (SPLIT < 2 || SPLIT != (2 ** SPLIT_LOG)) begin : validation

        $error("pry2oht_tree: SPLIT must be a power of two and at least 2");
        assign oht = '0;
        assign vld = 1'b0;

    end : validation
    else begin : build

        logic [POWER-1:0] pry_ext;
        logic [POWER-1:0] oht_ext;

        // zero extend, padded leaves never win
        assign pry_ext = POWER'(pry);

        // level 0 holds the leaves, level LEVELS the root
        for (genvar l = 0; l <= LEVELS; l++) begin : lvl
            localparam int unsigned N = SPLIT ** (LEVELS - l);

            // subtree holds at least one request
            logic [N-1:0] v;
            // subtree lies on the path to the winner
            logic [N-1:0] m;

            ////////////////////////////////////////////////////////////
            // upward pass, valid is the OR of the children
            if (l == 0) begin : leaf
                assign v = pry_ext;
            end : leaf
            else begin : inner
                for (genvar n = 0; n < N; n++) begin : node
                    assign v[n] = |lvl[l-1].v[n*SPLIT +: SPLIT];
                end : node
            end : inner

            ////////////////////////////////////////////////////////////
            // downward pass, each node keeps its rightmost valid child
            if (l == LEVELS) begin : root
                assign m = v;
            end : root
            else begin : child
                for (genvar n = 0; n < N; n++) begin : node
                    // position among the siblings
                    localparam int unsigned C = n % SPLIT;
                    if (C == 0) begin : first
                        assign m[n] = lvl[l+1].m[n/SPLIT] & v[n];
                    end : first
                    else begin : other
                        // any lower sibling with a request blocks this one
                        assign m[n] = lvl[l+1].m[n/SPLIT] & v[n] & ~|v[n-C +: C];
                    end : other
                end : node
            end : child
        end : lvl

        assign oht_ext = lvl[0].m;
        assign vld     = lvl[LEVELS].v;

        // drop the padding
        assign oht = WIDTH'(oht_ext);

    end : build
    endgenerate

endmodule

// File: irq_ctrl_apb_regs.sv
// input side of the interrupt controller
// APB slave with the enable mask, sticky pending bits and the read mux
// drives the masked active vector into the priority tree

`include "irq_ctrl_defines.svh"

module irq_ctrl_apb_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  irq_ctrl_pkg::irq_vec_t irq_src,
    input  irq_ctrl_pkg::apb_req_t apb_req,
    output irq_ctrl_pkg::apb_rsp_t apb_rsp,
    input  irq_ctrl_pkg::claim_t   claim,
    output irq_ctrl_pkg::irq_vec_t active
);

    ////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////

    // access phase, transfer completes here
    logic access;
    logic wr_en;
    logic rd_en;

    // address hits one of the four registers
    logic mapped;

    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite & mapped;
    assign rd_en  = access & ~apb_req.pwrite;

    ////////////////////////////////////////////////////////////
    // enable mask
    ////////////////////////////////////////////////////////////

    irq_ctrl_pkg::irq_vec_t enable;

    // plain read/write, one bit per source
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= '0;
        end else if (wr_en && apb_req.paddr == `IRQ_CTRL_REG_ENABLE) begin
            enable <= apb_req.pwdata[`IRQ_CTRL_NUM-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // sticky pending bits
    ////////////////////////////////////////////////////////////

    irq_ctrl_pkg::irq_vec_t pending;
    // bits to drop this cycle, from a CLEAR write
    irq_ctrl_pkg::irq_vec_t clr_mask;

    always_comb begin
        clr_mask = '0;
        if (wr_en && apb_req.paddr == `IRQ_CTRL_REG_CLEAR) begin
            clr_mask = apb_req.pwdata[`IRQ_CTRL_NUM-1:0];
        end
    end

    // write one to clear, a source still high sets the bit again
    // so setting wins over clearing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | irq_src;
        end
    end

    // requests that may win the priority tree
    assign active = pending & enable;

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    irq_ctrl_pkg::apb_data_t rdata;

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb_req.paddr)
            `IRQ_CTRL_REG_ENABLE: begin
                rdata = irq_ctrl_pkg::apb_data_t'(enable);
            end
            `IRQ_CTRL_REG_PENDING: begin
                rdata = irq_ctrl_pkg::apb_data_t'(pending);
            end
            `IRQ_CTRL_REG_CLEAR: begin
                // write only, reads back zero
                rdata = '0;
            end
            `IRQ_CTRL_REG_CLAIM: begin
                // valid flag on top, index in the low bits
                rdata[`IRQ_CTRL_DW-1]      = claim.vld;
                rdata[`IRQ_CTRL_ID_W-1:0] = claim.id;
            end
            default: begin
                // unmapped offset, zero data and slave error
                mapped = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // data only during a read access, otherwise held at zero
    assign apb_rsp.prdata  = rd_en ? rdata : '0;
    // error flagged in the access cycle of an unmapped transfer
    assign apb_rsp.pslverr = access & ~mapped;

endmodule

// File: irq_ctrl_pkg.sv
// types shared by the interrupt controller blocks and its testbench
// refer to them with irq_ctrl_pkg:: scoped names

`include "irq_ctrl_defines.svh"

package irq_ctrl_pkg;

    // one bit per interrupt source
    typedef logic [`IRQ_CTRL_NUM-1:0]  irq_vec_t;
    // index of a single source
    typedef logic [`IRQ_CTRL_ID_W-1:0] irq_id_t;
    // APB read/write data
    typedef logic [`IRQ_CTRL_DW-1:0]   apb_data_t;

    // APB request from the master side
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`IRQ_CTRL_AW-1:0] paddr;
        apb_data_t               pwdata;
    } apb_req_t;

    // APB response, completes in the access phase so no pready
    typedef struct packed {
        apb_data_t prdata;
        logic      pslverr;
    } apb_rsp_t;

    // registered winner of the priority selection
    typedef struct packed {
        logic    vld;
        irq_id_t id;
    } claim_t;

endpackage

// File: irq_ctrl_defines.svh
// shared sizing macros and register offsets for the interrupt controller
// include wherever the source count, APB widths or offsets are needed

`ifndef IRQ_CTRL_DEFINES_SVH
`define IRQ_CTRL_DEFINES_SVH

////////////////////////////////////////////////////////////
// source and tree sizing
////////////////////////////////////////////////////////////

// level sensitive interrupt sources
`define IRQ_CTRL_NUM 24
// branching factor of the priority tree, must be a power of two
`define IRQ_CTRL_SPLIT 2
// enough bits to index every source
`define IRQ_CTRL_ID_W 5

////////////////////////////////////////////////////////////
// APB widths and register map
////////////////////////////////////////////////////////////

`define IRQ_CTRL_AW 4
`define IRQ_CTRL_DW 32

// offsets are sized to IRQ_CTRL_AW
`define IRQ_CTRL_REG_ENABLE  4'h0
`define IRQ_CTRL_REG_PENDING 4'h4
`define IRQ_CTRL_REG_CLEAR   4'h8
`define IRQ_CTRL_REG_CLAIM   4'hC

`endif
